// ==== hdl/m68k_bus_pkg.sv ====
// address map and bus types of the 68k glue logic
// imported by the decoder, the remap, the stack memory and the top level
package m68k_bus_pkg;

	// ------------------------------
	// bus widths and types
	// ------------------------------
	localparam int adr_w = 32;

	typedef logic [15:0] word_t;	// one bus data word
	typedef logic [adr_w-1:0] adr_t;

	// ------------------------------
	// address map
	// ------------------------------
	// vector region is below 8 and the top 16 bytes
	localparam adr_t vec_lo_limit = 32'h0000_0008;
	localparam logic [27:0] vec_hi_base = 28'hFFF_FFFF;	// upper 28 bits

	// external ram from 8 up to below this
	localparam logic [15:0] ram_limit_hi = 16'hFFD0;

	localparam logic [15:0] rom_base_hi = 16'hFFFF;
	localparam logic [19:0] stk_base = 20'hFFFE0;	// 4 KB window, 2 KB used
	localparam logic [23:0] ctl_base = 24'hFFDD00;	// control register page

	// control registers
	localparam adr_t thread_ndx_adr = 32'hFFDD_0008;
	localparam adr_t tick_clear_adr = 32'hFFFF_0000;

	// page remapped by the thread index
	localparam logic [23:0] thread_page_hi = 24'h000100;

endpackage

// ==== hdl/m68k_sys_pkg.sv ====
// fixed system words, interrupt levels and register reset values
// imported where responses or interrupt levels are produced
package m68k_sys_pkg;

	// no-operation word, answers rom and unmapped reads
	localparam logic [15:0] fill_word = 16'h4E71;

	// ------------------------------
	// vector table
	// ------------------------------
	// entries 0..3 are the reset ssp and pc words
	// entries 4..11 are the words at FFFF_FFF0 .. FFFF_FFFE
	localparam logic [0:11][15:0] vec_word_table = {
		16'hFFFE, 16'h07FC, 16'hFFFF, 16'h1100,
		16'd31, 16'd30, 16'd29, 16'd28,
		16'd28, 16'd29, 16'd30, 16'd31
	};
	localparam logic [15:0] vec_default_word = 16'h3000;

	// ------------------------------
	// interrupts
	// ------------------------------
	typedef logic [2:0] irq_level_t;

	localparam irq_level_t irq_tick_level = 3'd6;
	localparam irq_level_t irq_kbd_level = 3'd7;	// keyboard reset, nmi level

	localparam logic [7:0] thread_ndx_reset = 8'h00;

endpackage

// ==== hdl/sys_bus_if.sv ====
// internal slave bus between the decoder and the memory slaves
// the decoder holds the master side, each slave one slave modport
`timescale 1ns/1ps

interface sys_bus_if import m68k_bus_pkg::*; ();

	logic sel;	// access active, both strobes low
	logic we;
	adr_t adr;
	word_t wdat;
	word_t rdat;
	logic ack;

	modport master (
		output sel,
		output we,
		output adr,
		output wdat,
		input rdat,
		input ack
	);

	modport slave (
		input sel,
		input we,
		input adr,
		input wdat,
		output rdat,
		output ack
	);

endinterface

// ==== hdl/addr_remap.sv ====
// thread index register and the remap of the thread page
// the decoder supplies the register write, the top routes the mapped address
`timescale 1ns/1ps

module addr_remap import m68k_bus_pkg::*, m68k_sys_pkg::*; (
	input logic clk25,
	input logic rst,
	input logic wr_i,	// write cycle to thread_ndx_adr
	input word_t wdat_i,
	input adr_t cpu_adr_i,
	output logic [7:0] thread_ndx_o,
	output adr_t phys_adr_o
);

	logic [7:0] ndx_q;
	logic in_page;

	// ------------------------------
	// thread index register
	// ------------------------------
	always_ff @(posedge clk25 or posedge rst) begin
		if (rst) begin
			ndx_q <= thread_ndx_reset;
		end else if (wr_i) begin
			ndx_q <= wdat_i[7:0];	// low byte only
		end
	end

	assign thread_ndx_o = ndx_q;

	// ------------------------------
	// page remap
	// ------------------------------
	assign in_page = (cpu_adr_i[31:8] == thread_page_hi);

	// middle byte selects the thread's slice of external ram
	assign phys_adr_o = in_page ? {cpu_adr_i[31:16], ndx_q, cpu_adr_i[7:0]}
		: cpu_adr_i;

endmodule

// ==== hdl/stack_ram.sv ====
// on-chip stack memory with a delayed acknowledge
// depth and acknowledge delay come from the top level
`timescale 1ns/1ps

module stack_ram import m68k_bus_pkg::*; #(
	parameter int stack_words = 1024,	// at least 2
	parameter int stack_ack_delay = 4	// edges from strobes low to ack
) (
	input logic clk25,
	input logic rst,
	sys_bus_if.slave bus
);

	localparam int aw = $clog2(stack_words);
	localparam int cw = $clog2(stack_ack_delay + 1);

	word_t mem [stack_words];
	word_t rdat_q;
	logic [aw-1:0] word_adr;
	logic [cw-1:0] dly_cnt;

	assign word_adr = bus.adr[aw:1];	// word addressed, bit 0 ignored

	// ------------------------------
	// memory array
	// ------------------------------
	always_ff @(posedge clk25) begin
		if (bus.sel) begin
			if (bus.we) begin
				mem[word_adr] <= bus.wdat;	// last edge wins
			end
			rdat_q <= mem[word_adr];
		end
	end

	// acknowledge delay, restarts whenever the access drops
	always_ff @(posedge clk25 or posedge rst) begin
		if (rst) begin
			dly_cnt <= '0;
		end else if (!bus.sel) begin
			dly_cnt <= '0;
		end else if (dly_cnt != cw'(stack_ack_delay)) begin
			dly_cnt <= dly_cnt + 1'b1;
		end
	end

	assign bus.ack = (dly_cnt == cw'(stack_ack_delay));
	assign bus.rdat = rdat_q;

endmodule

// ==== hdl/vector_rom.sv ====
// fixed read responses for the vector and rom regions
// both regions share this slave, rom_i tells them apart
`timescale 1ns/1ps

module vector_rom import m68k_sys_pkg::*; (
	sys_bus_if.slave bus,
	input logic rom_i	// rom region, else vector region
);

	logic [15:0] vec_word;

	// ------------------------------
	// vector lookup
	// ------------------------------
	// bit 31 splits the low reset words from the top vectors
	always_comb begin
		case ({bus.adr[31], bus.adr[3:1]})
			4'b0000: vec_word = vec_word_table[0];	// reset ssp
			4'b0001: vec_word = vec_word_table[1];
			4'b0010: vec_word = vec_word_table[2];	// reset pc
			4'b0011: vec_word = vec_word_table[3];
			4'b1000: vec_word = vec_word_table[4];
			4'b1001: vec_word = vec_word_table[5];
			4'b1010: vec_word = vec_word_table[6];
			4'b1011: vec_word = vec_word_table[7];
			4'b1100: vec_word = vec_word_table[8];
			4'b1101: vec_word = vec_word_table[9];
			4'b1110: vec_word = vec_word_table[10];
			4'b1111: vec_word = vec_word_table[11];
			default: vec_word = vec_default_word;
		endcase
	end

	// rom contents not kept, every rom word reads as a nop
	assign bus.rdat = rom_i ? fill_word : vec_word;

	// zero wait states
	assign bus.ack = bus.sel;

endmodule

// ==== hdl/irq_ctrl.sv ====
// tick interrupt latch and cpu interrupt priority encoder
// output is the active-low ipl code for the cpu
`timescale 1ns/1ps

module irq_ctrl import m68k_sys_pkg::*; (
	input logic clk25,
	input logic rst,
	input logic tick_i,	// one cycle pulse
	input logic clear_i,	// access at tick_clear_adr
	input logic kbd_rst_i,
	output irq_level_t ipl_n_o
);

	logic tick_q;
	irq_level_t level;

	// pending tick, held until software clears it
	always_ff @(posedge clk25 or posedge rst) begin
		if (rst) begin
			tick_q <= 1'b0;
		end else if (tick_i) begin
			tick_q <= 1'b1;	// new tick beats a clear
		end else if (clear_i) begin
			tick_q <= 1'b0;
		end
	end

	// highest source wins
	always_comb begin
		if (kbd_rst_i) level = irq_kbd_level;
		else if (tick_q) level = irq_tick_level;
		else level = '0;
	end

	assign ipl_n_o = ~level;

endmodule

// ==== hdl/bus_decoder.sv ====
// region decode, acknowledge combining and read data mux for the 68k bus
// drives the internal slaves and the external ram select
`timescale 1ns/1ps

module bus_decoder import m68k_bus_pkg::*, m68k_sys_pkg::*; (
	input logic as_n_i,
	input logic uds_n_i,
	input logic lds_n_i,
	input logic rw_i,
	input adr_t cpu_adr_i,
	input adr_t phys_adr_i,	// after thread remap
	input logic [7:0] thread_ndx_i,
	input word_t wdat_i,
	input logic ram_ack_i,
	input word_t ram_rdat_i,
	output word_t rdat_o,
	output logic dtack_n_o,
	output logic ram_sel_o,
	output logic tw_o,	// thread index write
	output logic tick_clr_o,
	output logic rom_o,
	sys_bus_if.master stk_bus,
	sys_bus_if.master vec_bus
);

	logic active;
	logic cs_vec, cs_rom, cs_ram, cs_stk, cs_ctl;

	// full word access in progress
	assign active = !as_n_i && !uds_n_i && !lds_n_i;

	// ------------------------------
	// region decode
	// ------------------------------
	assign cs_vec = (cpu_adr_i < vec_lo_limit) || (cpu_adr_i[31:4] == vec_hi_base);
	assign cs_rom = (cpu_adr_i[31:16] == rom_base_hi) && !cs_vec;	// vectors win
	assign cs_ram = (cpu_adr_i >= vec_lo_limit) && (cpu_adr_i[31:16] < ram_limit_hi);
	assign cs_stk = (phys_adr_i[31:12] == stk_base);
	assign cs_ctl = (cpu_adr_i[31:8] == ctl_base);

	assign tw_o = active && !rw_i && (cpu_adr_i == thread_ndx_adr);
	assign tick_clr_o = active && (cpu_adr_i == tick_clear_adr);
	assign rom_o = cs_rom;
	assign ram_sel_o = active && cs_ram;

	// slave buses
	assign vec_bus.sel = active && (cs_vec || cs_rom);
	assign vec_bus.we = !rw_i;
	assign vec_bus.adr = cpu_adr_i;
	assign vec_bus.wdat = wdat_i;

	assign stk_bus.sel = active && cs_stk;
	assign stk_bus.we = !rw_i;
	assign stk_bus.adr = phys_adr_i;
	assign stk_bus.wdat = wdat_i;

	// ------------------------------
	// acknowledge and read data
	// ------------------------------
	// control page answers at once, unmapped never
	assign dtack_n_o = !(active && (vec_bus.ack || stk_bus.ack || cs_ctl
		|| (cs_ram && ram_ack_i)));

	always_comb begin
		if (cs_vec || cs_rom) rdat_o = vec_bus.rdat;
		else if (cs_stk) rdat_o = stk_bus.rdat;
		else if (cs_ctl && cpu_adr_i == thread_ndx_adr) rdat_o = {2{thread_ndx_i}};
		else if (cs_ram) rdat_o = ram_rdat_i;
		else rdat_o = fill_word;	// other control regs too
	end

endmodule

// ==== hdl/m68k_glue_top.sv ====
// bus glue of the 68k test system, cpu and external ram sit outside
// instances and wiring only, stack size and delay set here
`timescale 1ns/1ps

module m68k_glue_top import m68k_bus_pkg::*; #(
	parameter int stack_words = 1024,
	parameter int stack_ack_delay = 4
) (
	input logic clk25,
	input logic rst,
	// cpu bus
	input logic as_n_i,
	input logic uds_n_i,
	input logic lds_n_i,
	input logic rw_i,
	input adr_t adr_i,
	input word_t wdat_i,
	output word_t rdat_o,
	output logic dtack_n_o,
	output logic [2:0] ipl_n_o,
	// interrupt sources
	input logic tick_i,
	input logic kbd_rst_i,
	// external ram
	output logic ram_sel_o,
	output adr_t ram_adr_o,
	input logic ram_ack_i,
	input word_t ram_rdat_i
);

	logic tw, tick_clr, rom;
	logic [7:0] thread_ndx;

	sys_bus_if stk_bus ();
	sys_bus_if vec_bus ();

	bus_decoder u_dec (
		.as_n_i, .uds_n_i, .lds_n_i, .rw_i,
		.cpu_adr_i(adr_i), .phys_adr_i(ram_adr_o), .thread_ndx_i(thread_ndx),
		.wdat_i, .ram_ack_i, .ram_rdat_i, .rdat_o, .dtack_n_o, .ram_sel_o,
		.tw_o(tw), .tick_clr_o(tick_clr), .rom_o(rom),
		.stk_bus(stk_bus.master), .vec_bus(vec_bus.master)
	);

	addr_remap u_remap (
		.clk25, .rst, .wr_i(tw), .wdat_i, .cpu_adr_i(adr_i),
		.thread_ndx_o(thread_ndx), .phys_adr_o(ram_adr_o)
	);

	stack_ram #(.stack_words(stack_words), .stack_ack_delay(stack_ack_delay)) u_stk (
		.clk25, .rst, .bus(stk_bus.slave)
	);

	vector_rom u_vec (.bus(vec_bus.slave), .rom_i(rom));

	irq_ctrl u_irq (
		.clk25, .rst, .tick_i, .clear_i(tick_clr), .kbd_rst_i, .ipl_n_o
	);

endmodule

// ==== tests/tb_top.sv ====
// testbench for the 68k bus glue that drives the cpu bus and models the external ram
// compiled from tb.f with tb_top as the top module
`timescale 1ns/1ps

module tb_top;

	localparam int stack_delay = 3;
	localparam int ack_limit = 30;	// cycles a mapped access may take
	localparam int planned_cycles = 45;
	localparam int watchdog_ns = (16 + planned_cycles * (ack_limit + 4) + 100) * 40;

	// reset words followed by the words at FFFF_FFF0 .. FFFF_FFFE
	localparam logic [0:11][15:0] vec_exp = {
		16'hFFFE, 16'h07FC, 16'hFFFF, 16'h1100,
		16'd31, 16'd30, 16'd29, 16'd28, 16'd28, 16'd29, 16'd30, 16'd31
	};
	localparam logic [0:3][31:0] stk_adr = {
		32'hFFFE_0000, 32'hFFFE_0002, 32'hFFFE_07FE, 32'hFFFE_0136
	};

	logic clk25, rst;
	logic as_n_i, uds_n_i, lds_n_i, rw_i;
	logic [31:0] adr_i;
	logic [15:0] wdat_i, rdat_o;
	logic dtack_n_o;
	logic [2:0] ipl_n_o;
	logic tick_i, kbd_rst_i;
	logic ram_sel_o, ram_ack_i;
	logic [31:0] ram_adr_o;
	logic [15:0] ram_rdat_i;

	logic [31:0] stim_rng = 32'h2a69;
	logic [31:0] ram_rng = 32'h2a69;	// own state for the ram model
	logic [31:0] seen_ram_adr;

	m68k_glue_top #(.stack_words(1024), .stack_ack_delay(stack_delay)) u_dut (.*);

	initial begin
		clk25 = 1'b0;
		forever #20 clk25 = ~clk25;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// data pattern of the external ram model
	function automatic logic [15:0] ram_word(input logic [31:0] a);
		return a[31:16] ^ {a[14:0], a[15]} ^ 16'hC3A5;
	endfunction

	function automatic logic [31:0] expect_ram_adr(input logic [31:0] a, input logic [7:0] t);
		if (a[31:8] == 24'h000100)
			return {a[31:16], t, a[7:0]};	// thread page
		return a;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic value_error(input string msg);
		abort_run($sformatf("error at %0t ns: %s", $time, msg));
	endtask

	// ------------------------------
	// cpu bus cycles
	// ------------------------------
	task automatic bus_cycle(input logic rd, input logic [31:0] a, input logic [15:0] wd,
		input int limit, output logic [15:0] d, output int edges, output logic acked);
		@(posedge clk25);
		as_n_i <= 1'b0;
		uds_n_i <= 1'b0;
		lds_n_i <= 1'b0;
		rw_i <= rd;
		adr_i <= a;
		wdat_i <= wd;
		edges = 0;
		acked = 1'b0;
		d = '0;
		while (!acked && edges <= limit) begin
			@(negedge clk25);	// outputs settled here
			if (!dtack_n_o) begin
				acked = 1'b1;
				d = rdat_o;
				seen_ram_adr = ram_adr_o;
			end else begin
				edges++;
			end
		end
		@(posedge clk25);
		as_n_i <= 1'b1;
		uds_n_i <= 1'b1;
		lds_n_i <= 1'b1;
		rw_i <= 1'b1;
		@(posedge clk25);
	endtask

	task automatic access(input logic rd, input logic [31:0] a, input logic [15:0] wd,
		output logic [15:0] d, output int edges);
		logic acked;
		bus_cycle(rd, a, wd, ack_limit, d, edges, acked);
		if (!acked)
			abort_run($sformatf("no dtack for the access at address %h", a));
	endtask

	// external ram model with a random latency of 0 to 5 cycles
	initial begin
		int delay;
		ram_ack_i = 1'b0;
		ram_rdat_i = '0;
		forever begin
			@(posedge clk25);
			if (ram_sel_o) begin
				ram_rng = xorshift(ram_rng);
				delay = ram_rng % 6;
				repeat (delay) @(posedge clk25);
				ram_rdat_i <= ram_word(ram_adr_o);
				ram_ack_i <= 1'b1;
				while (ram_sel_o) @(posedge clk25);
				ram_ack_i <= 1'b0;
			end
		end
	end

	// ------------------------------
	// bus rules checked every cycle
	// ------------------------------
	assert property (@(posedge clk25) disable iff (rst)
		(as_n_i || uds_n_i || lds_n_i) |-> dtack_n_o)
		else value_error("dtack low while the strobes are high");
	assert property (@(posedge clk25) disable iff (rst) (ram_sel_o && !ram_ack_i) |-> dtack_n_o)
		else value_error("dtack low before the ram acknowledged");
	assert property (@(posedge clk25) disable iff (rst) kbd_rst_i |-> (ipl_n_o == 3'b000))
		else value_error("keyboard reset did not raise level 7");

	initial begin
		#(watchdog_ns);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		logic [15:0] d;
		logic [15:0] stk_data [4];
		logic [31:0] a;
		logic [7:0] thread_ndx;
		logic acked;
		int edges;
		rst = 1'b1;
		as_n_i = 1'b1;
		uds_n_i = 1'b1;
		lds_n_i = 1'b1;
		rw_i = 1'b1;
		adr_i = '0;
		wdat_i = '0;
		tick_i = 1'b0;
		kbd_rst_i = 1'b0;
		repeat (16) @(posedge clk25);
		rst <= 1'b0;
		@(negedge clk25);
		assert (dtack_n_o && ipl_n_o == 3'b111 && !ram_sel_o)
			else value_error("outputs not idle after reset");
		access(1'b1, 32'hFFDD_0008, 16'h0, d, edges);
		assert (d == 16'h0000)
			else value_error($sformatf("thread index read %h after reset", d));

		// vectors answer in the same cycle
		for (int i = 0; i < 12; i++) begin
			a = (i < 4) ? 32'(2 * i) : 32'hFFFF_FFF0 + 32'(2 * (i - 4));
			access(1'b1, a, 16'h0, d, edges);
			assert (d == vec_exp[i] && edges == 0)
				else value_error($sformatf("vector %h read %h after %0d edges", a, d, edges));
		end

		// stack write then read back
		for (int i = 0; i < 4; i++) begin
			stim_rng = xorshift(stim_rng);
			stk_data[i] = stim_rng[15:0];
			access(1'b0, stk_adr[i], stk_data[i], d, edges);
			assert (edges == stack_delay)
				else value_error($sformatf("stack write acked after %0d edges", edges));
		end
		for (int i = 0; i < 4; i++) begin
			access(1'b1, stk_adr[i], 16'h0, d, edges);
			assert (d == stk_data[i] && edges == stack_delay)
				else value_error($sformatf("stack %h read %h, expected %h", stk_adr[i], d,
					stk_data[i]));
		end

		// thread index register
		stim_rng = xorshift(stim_rng);
		thread_ndx = stim_rng[7:0];
		access(1'b0, 32'hFFDD_0008, stim_rng[15:0], d, edges);
		access(1'b1, 32'hFFDD_0008, 16'h0, d, edges);
		assert (d == {2{thread_ndx}})
			else value_error($sformatf("thread index read %h, expected %h", d, thread_ndx));

		// external ram in the thread page first and then outside it
		for (int i = 0; i < 8; i++) begin
			stim_rng = xorshift(stim_rng);
			if (i == 0) a = 32'h0001_0024;
			else if (i == 1) a = 32'h0002_1234;
			else a = (stim_rng & 32'h7FFF_FFFE) | 32'h10;
			access(1'b1, a, 16'h0, d, edges);
			assert (seen_ram_adr == expect_ram_adr(a, thread_ndx))
				else value_error($sformatf("ram address %h for cpu address %h", seen_ram_adr, a));
			assert (d == ram_word(expect_ram_adr(a, thread_ndx)))
				else value_error($sformatf("ram read %h at %h", d, a));
		end

		// tick holds level 6 until the clear address is read
		@(posedge clk25);
		tick_i <= 1'b1;
		@(posedge clk25);
		tick_i <= 1'b0;
		repeat (3) begin
			@(negedge clk25);
			assert (ipl_n_o == 3'b001) else value_error("tick did not raise level 6");
		end

		// keyboard reset overrides the pending tick
		@(posedge clk25);
		kbd_rst_i <= 1'b1;
		@(negedge clk25);
		assert (ipl_n_o == 3'b000) else value_error("keyboard reset level wrong");
		@(posedge clk25);
		kbd_rst_i <= 1'b0;
		@(negedge clk25);
		assert (ipl_n_o == 3'b001) else value_error("tick lost during keyboard reset");

		access(1'b1, 32'hFFFF_0000, 16'h0, d, edges);
		assert (d == 16'h4E71 && edges == 0) else value_error($sformatf("rom read %h", d));
		@(negedge clk25);
		assert (ipl_n_o == 3'b111) else value_error("tick not cleared");

		// unmapped address where the cpu gives up after 20 cycles
		bus_cycle(1'b1, 32'hFFE0_0000, 16'h0, 20, d, edges, acked);
		assert (!acked) else value_error("unmapped address FFE00000 acknowledged");

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== tb.f ====
hdl/m68k_bus_pkg.sv
hdl/m68k_sys_pkg.sv
hdl/sys_bus_if.sv
hdl/addr_remap.sv
hdl/stack_ram.sv
hdl/vector_rom.sv
hdl/irq_ctrl.sv
hdl/bus_decoder.sv
hdl/m68k_glue_top.sv
tests/tb_top.sv

// ==== Bender.yml ====
package:
  name: m68k_glue

sources:
  - hdl/m68k_bus_pkg.sv
  - hdl/m68k_sys_pkg.sv
  - hdl/sys_bus_if.sv
  - hdl/addr_remap.sv
  - hdl/stack_ram.sv
  - hdl/vector_rom.sv
  - hdl/irq_ctrl.sv
  - hdl/bus_decoder.sv
  - hdl/m68k_glue_top.sv
  - target: simulation
    files:
      - tests/tb_top.sv
